// ==== Makefile ====
# Verilator flow for the mcu io fabric

TOP := tb_mcu_io

.PHONY: all lint sim clean

all: sim

# lint the RTL top on its own, then the testbench
lint:
	verilator --lint-only --timing --top-module mcu_io_top -f flist.f
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

# build, run, and pass only if the log holds the pass line
sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== flist.f ====
+incdir+include
hw/mcu_io_pkg.sv
hw/std_reg.sv
hw/load_decoder.sv
hw/reg_readback.sv
hw/av_write_master.sv
hw/mcu_io_top.sv
testbench/av_slave_model.sv
testbench/tb_mcu_io.sv

// ==== hw/av_write_master.sv ====
`timescale 1ns/1ps

// write-only avalon master
// one write per start, held until waitrequest drops
module av_write_master (
    input  logic                 sysclk,
    input  logic                 reset,
    input  logic                 start,
    input  mcu_io_pkg::av_cmd_t  cmd_in,
    input  logic                 av_waitrequest,
    output logic                 av_write,
    output mcu_io_pkg::av_cmd_t  av_cmd,
    output logic                 busy
);

    // write strobe
    // start never arrives while busy, the decoder blocks it
    always_ff @(posedge sysclk) begin
        if (reset) begin
            av_write <= 1'b0;
        end else if (av_write && !av_waitrequest) begin
            // slave took it
            av_write <= 1'b0;
        end else if (start) begin
            av_write <= 1'b1;
        end
    end

    // command held for the whole transfer
    // later address writes do not disturb it
    always_ff @(posedge sysclk) begin
        if (start) begin
            av_cmd <= cmd_in;
        end
    end

    // Busy for exactly as long as the strobe is up.
    assign busy = av_write;

endmodule

// ==== hw/load_decoder.sv ====
`timescale 1ns/1ps
`include "mcu_io_defines.svh"

// turns each accepted host write into a one-hot load pulse
module load_decoder (
    input  logic                        sysclk,
    input  logic                        reset,
    input  logic                        wr_valid,
    input  mcu_io_pkg::reg_write_t      wr_req,
    input  logic                        busy,
    output logic [`MCU_IO_TOP_REG:0]    load,
    output mcu_io_pkg::reg_word_t       load_data,
    output logic                        ready
);

    logic [`MCU_IO_TOP_REG:0] hit;
    logic                     is_keys;
    logic                     is_av_data;
    logic                     accept;
    logic                     ready_en;
    mcu_io_pkg::reg_word_t    data_q;

    // address to one-hot, unmapped addresses give no hit
    always_comb begin
        hit = '0;
        for (int i = 0; i <= `MCU_IO_TOP_REG; i++) begin
            if (wr_req.addr == mcu_io_pkg::reg_addr_t'(i)) begin
                hit[i] = 1'b1;
            end
        end
    end

    assign is_keys    = (wr_req.addr == `MCU_IO_SR_KEYS);
    assign is_av_data = (wr_req.addr == `MCU_IO_DR_AV_WRITEDATA);

    // key reg is read-only
    // data reg write only when the bus side can take it
    assign accept = wr_valid && !is_keys && (!is_av_data || ready);

    // holds ready low for the first cycle out of reset
    always_ff @(posedge sysclk) begin
        if (reset) begin
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
        end
    end

    // load pulse lasts one cycle
    always_ff @(posedge sysclk) begin
        if (reset) begin
            load <= '0;
        end else if (accept) begin
            load <= hit;
        end else begin
            load <= '0;
        end
    end

    // write data, shared by every register
    always_ff @(posedge sysclk) begin
        if (wr_valid) begin
            data_q <= wr_req.data;
        end
    end

    assign load_data = data_q;

    // pending data load covers the cycle before av_write rises
    // so ready has no gap between strobe and busy
    assign ready = ready_en && !busy && !load[`MCU_IO_DR_AV_WRITEDATA];

endmodule

// ==== hw/mcu_io_pkg.sv ====
package mcu_io_pkg;

    // one register word, same width as the mcu data path
    typedef logic [15:0] reg_word_t;

    // register address, 16 slots of which 12 are mapped
    typedef logic [3:0] reg_addr_t;

    // led output byte
    typedef logic [7:0] led_t;

    // host write request
    // addr in the top bits, data in the low word
    typedef struct packed {
        reg_addr_t addr;
        reg_word_t data;
    } reg_write_t;

    // one bus write command
    // address word and data word as held for the slave
    typedef struct packed {
        reg_word_t address;
        reg_word_t writedata;
    } av_cmd_t;

endpackage

// ==== hw/mcu_io_top.sv ====
`timescale 1ns/1ps
`include "mcu_io_defines.svh"

// register-mapped io fabric between the mcu and its peripherals
module mcu_io_top (
    input  logic                         sysclk,
    input  logic                         reset,
    input  logic                         wr_valid,
    input  mcu_io_pkg::reg_write_t       wr_req,
    input  mcu_io_pkg::reg_addr_t        rd_addr,
    output mcu_io_pkg::reg_word_t        rd_data,
    output logic                         ready,
    input  logic [`MCU_IO_NUM_KEYS-1:0]  keys,
    output mcu_io_pkg::led_t             leds,
    input  logic                         av_waitrequest,
    output logic                         av_write,
    output mcu_io_pkg::av_cmd_t          av_cmd
);

    logic [`MCU_IO_TOP_REG:0] load;
    mcu_io_pkg::reg_word_t    load_data;
    mcu_io_pkg::reg_word_t    gp_regs [`MCU_IO_TOP_GP:0];
    mcu_io_pkg::reg_word_t    av_address_q;
    mcu_io_pkg::reg_word_t    av_writedata_q;
    mcu_io_pkg::av_cmd_t      reg_cmd;
    mcu_io_pkg::av_cmd_t      start_cmd;
    logic                     busy;

    // host writes to one-hot loads
    load_decoder u_decoder (
        .sysclk    (sysclk),
        .reset     (reset),
        .wr_valid  (wr_valid),
        .wr_req    (wr_req),
        .busy      (busy),
        .load      (load),
        .load_data (load_data),
        .ready     (ready)
    );

    // general-purpose bank
    for (genvar g = 0; g <= `MCU_IO_TOP_GP; g++) begin : g_gp
        std_reg u_gp_reg (
            .sysclk (sysclk),
            .reset  (reset),
            .d      (load_data),
            .load   (load[g]),
            .q      (gp_regs[g])
        );
    end

    // led byte drives the pins directly
    std_reg #(
        .payload_t (mcu_io_pkg::led_t)
    ) u_led_reg (
        .sysclk (sysclk),
        .reset  (reset),
        .d      (load_data[7:0]),
        .load   (load[`MCU_IO_DR_LEDS]),
        .q      (leds)
    );

    // bus address, write it before the data reg
    std_reg u_av_address_reg (
        .sysclk (sysclk),
        .reset  (reset),
        .d      (load_data),
        .load   (load[`MCU_IO_DR_AV_ADDRESS]),
        .q      (av_address_q)
    );

    // bus data
    std_reg u_av_writedata_reg (
        .sysclk (sysclk),
        .reset  (reset),
        .d      (load_data),
        .load   (load[`MCU_IO_DR_AV_WRITEDATA]),
        .q      (av_writedata_q)
    );

    // register view for readback
    assign reg_cmd = '{address: av_address_q, writedata: av_writedata_q};

    // data reg loads in the start cycle, so take load_data
    assign start_cmd = '{address: av_address_q, writedata: load_data};

    reg_readback u_readback (
        .sysclk  (sysclk),
        .reset   (reset),
        .rd_addr (rd_addr),
        .gp_regs (gp_regs),
        .leds    (leds),
        .av_cmd  (reg_cmd),
        .keys    (keys),
        .rd_data (rd_data)
    );

    // data reg load is the start pulse
    av_write_master u_av_master (
        .sysclk         (sysclk),
        .reset          (reset),
        .start          (load[`MCU_IO_DR_AV_WRITEDATA]),
        .cmd_in         (start_cmd),
        .av_waitrequest (av_waitrequest),
        .av_write       (av_write),
        .av_cmd         (av_cmd),
        .busy           (busy)
    );

endmodule

// ==== hw/reg_readback.sv ====
`timescale 1ns/1ps
`include "mcu_io_defines.svh"

// key sync plus registered read mux over the whole register map
module reg_readback (
    input  logic                          sysclk,
    input  logic                          reset,
    input  mcu_io_pkg::reg_addr_t         rd_addr,
    input  mcu_io_pkg::reg_word_t         gp_regs [`MCU_IO_TOP_GP:0],
    input  mcu_io_pkg::led_t              leds,
    input  mcu_io_pkg::av_cmd_t           av_cmd,
    input  logic [`MCU_IO_NUM_KEYS-1:0]   keys,
    output mcu_io_pkg::reg_word_t         rd_data
);

    logic [`MCU_IO_NUM_KEYS-1:0] key_meta;
    logic [`MCU_IO_NUM_KEYS-1:0] key_sync;
    mcu_io_pkg::reg_word_t       gp_sel;
    mcu_io_pkg::reg_word_t       rd_next;

    // two-flop sync, keys come straight from the pins
    always_ff @(posedge sysclk) begin
        if (reset) begin
            key_meta <= '0;
            key_sync <= '0;
        end else begin
            key_meta <= keys;
            key_sync <= key_meta;
        end
    end

    // gp select, zero outside the gp range
    always_comb begin
        gp_sel = '0;
        for (int i = 0; i <= `MCU_IO_TOP_GP; i++) begin
            if (rd_addr == mcu_io_pkg::reg_addr_t'(i)) begin
                gp_sel = gp_regs[i];
            end
        end
    end

    // peripherals override; leds and keys zero-extended
    always_comb begin
        case (rd_addr)
            `MCU_IO_DR_LEDS:         rd_next = mcu_io_pkg::reg_word_t'(leds);
            `MCU_IO_DR_AV_ADDRESS:   rd_next = av_cmd.address;
            `MCU_IO_DR_AV_WRITEDATA: rd_next = av_cmd.writedata;
            `MCU_IO_SR_KEYS:         rd_next = mcu_io_pkg::reg_word_t'(key_sync);
            default:                 rd_next = gp_sel;
        endcase
    end

    // one cycle from rd_addr to rd_data
    always_ff @(posedge sysclk) begin
        if (reset) begin
            rd_data <= '0;
        end else begin
            rd_data <= rd_next;
        end
    end

endmodule

// ==== hw/std_reg.sv ====
`timescale 1ns/1ps

// loadable register, shared by gp words, led byte and bus regs
module std_reg #(
    parameter type payload_t = mcu_io_pkg::reg_word_t
) (
    input  logic     sysclk,
    input  logic     reset,
    input  payload_t d,
    input  logic     load,
    output payload_t q
);

    // all registers read zero after reset
    always_ff @(posedge sysclk) begin
        if (reset) begin
            q <= '0;
        end else if (load) begin
            // capture the shared load data
            q <= d;
        end
    end

endmodule

// ==== include/mcu_io_defines.svh ====
`ifndef MCU_IO_DEFINES_SVH
`define MCU_IO_DEFINES_SVH

// register file shape
// highest register index, general-purpose plus peripherals
`define MCU_IO_TOP_REG 11

// highest general-purpose index, gp regs are 0 to 7
`define MCU_IO_TOP_GP 7

// peripheral register addresses, 4-bit to match reg_addr_t
// led output byte
`define MCU_IO_DR_LEDS 4'd8

// bus address word for the next write
`define MCU_IO_DR_AV_ADDRESS 4'd9

// bus data word; a load here starts the bus write
`define MCU_IO_DR_AV_WRITEDATA 4'd10

// synchronized keys, read-only
`define MCU_IO_SR_KEYS 4'd11

// addresses 12 to 15 unmapped

// key input pins
`define MCU_IO_NUM_KEYS 2

`endif

// ==== testbench/av_slave_model.sv ====
`timescale 1ns/1ps

// avalon write slave with random waitrequest
// reports each accepted write for one cycle
module av_slave_model #(
    parameter int seed_init = 46100
) (
    input  logic                sysclk,
    input  logic                reset,
    input  logic                av_write,
    input  mcu_io_pkg::av_cmd_t av_cmd,
    output logic                av_waitrequest,
    output logic                accepted,
    output mcu_io_pkg::av_cmd_t accepted_cmd
);

    integer              seed = seed_init;
    int                  hold = 0;
    logic                wait_q = 1'b1;
    logic                accepted_q = 1'b0;
    mcu_io_pkg::av_cmd_t cmd_q = '0;

    always @(posedge sysclk) begin
        accepted_q <= 1'b0;
        if (reset) begin
            hold   <= 1;
            wait_q <= 1'b1;
        end else if (av_write && !wait_q) begin
            // write taken on this edge
            accepted_q <= 1'b1;
            cmd_q      <= av_cmd;
            // hold waitrequest for 2 to 7 cycles of the next write
            wait_q     <= 1'b1;
            hold       <= 1 + $unsigned($random(seed)) % 6;
        end else if (av_write) begin
            // stall counts only while a write is up
            if (hold != 0) begin
                hold <= hold - 1;
            end else begin
                wait_q <= 1'b0;
            end
        end
    end

    assign av_waitrequest = wait_q;
    assign accepted       = accepted_q;
    assign accepted_cmd   = cmd_q;

endmodule

// ==== testbench/tb_mcu_io.sv ====
`timescale 1ns/1ps
`include "mcu_io_defines.svh"

module tb_mcu_io;

    localparam int n_gp   = 40;
    localparam int n_bus  = 20;
    localparam int n_busy = 10;
    // rough cycle cost per phase with reset and idle reads included
    localparam int stim_cycles = 150 + n_gp * 6 + n_bus * 20 + n_busy * 24;
    localparam int cycle_limit = 4 * stim_cycles;

    logic                        sysclk   = 1'b0;
    logic                        reset    = 1'b1;
    logic                        wr_valid = 1'b0;
    mcu_io_pkg::reg_write_t      wr_req   = '0;
    mcu_io_pkg::reg_addr_t       rd_addr  = '0;
    logic [`MCU_IO_NUM_KEYS-1:0] keys     = '0;
    mcu_io_pkg::reg_word_t       rd_data;
    logic                        ready;
    mcu_io_pkg::led_t            leds;
    logic                        av_waitrequest;
    logic                        av_write;
    mcu_io_pkg::av_cmd_t         av_cmd;
    logic                        accepted;
    mcu_io_pkg::av_cmd_t         accepted_cmd;

    // reference model state
    mcu_io_pkg::reg_word_t       ref_regs [0:15];
    logic [`MCU_IO_NUM_KEYS-1:0] ref_keys = '0;
    mcu_io_pkg::av_cmd_t         exp_q [$];
    mcu_io_pkg::av_cmd_t         want_cmd;

    integer      seed = 46100;
    logic [31:0] rnd;
    logic        took;
    int          errors     = 0;
    int          checks     = 0;
    int          bus_writes = 0;
    int          want_bus   = 0;
    int          cycles     = 0;

    always #50 sysclk = ~sysclk;

    mcu_io_top dut0 (
        .sysclk         (sysclk),
        .reset          (reset),
        .wr_valid       (wr_valid),
        .wr_req         (wr_req),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .ready          (ready),
        .keys           (keys),
        .leds           (leds),
        .av_waitrequest (av_waitrequest),
        .av_write       (av_write),
        .av_cmd         (av_cmd)
    );

    av_slave_model slave0 (
        .sysclk         (sysclk),
        .reset          (reset),
        .av_write       (av_write),
        .av_cmd         (av_cmd),
        .av_waitrequest (av_waitrequest),
        .accepted       (accepted),
        .accepted_cmd   (accepted_cmd)
    );

    // expected read word per the register map
    function automatic mcu_io_pkg::reg_word_t expected_read(input mcu_io_pkg::reg_addr_t addr);
        mcu_io_pkg::reg_word_t word;
        case (addr)
            `MCU_IO_DR_LEDS:         word = {8'h00, ref_regs[addr][7:0]};
            `MCU_IO_SR_KEYS:         word = mcu_io_pkg::reg_word_t'(ref_keys);
            4'd12, 4'd13, 4'd14, 4'd15: word = '0;
            default:                 word = ref_regs[addr];
        endcase
        return word;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    // one write strobe that updates the reference if the decoder takes it
    task automatic host_write(input mcu_io_pkg::reg_addr_t waddr,
                              input mcu_io_pkg::reg_word_t wdata, output logic take);
        mcu_io_pkg::av_cmd_t cmd;
        @(posedge sysclk);
        wr_valid <= 1'b1;
        wr_req   <= '{addr: waddr, data: wdata};
        // ready here is what the decoder samples on the next edge
        @(negedge sysclk);
        take = (waddr < `MCU_IO_SR_KEYS) && (waddr != `MCU_IO_DR_AV_WRITEDATA || ready);
        if (take) begin
            ref_regs[waddr] = wdata;
        end
        if (take && waddr == `MCU_IO_DR_AV_WRITEDATA) begin
            cmd.address   = ref_regs[`MCU_IO_DR_AV_ADDRESS];
            cmd.writedata = wdata;
            exp_q.push_back(cmd);
            want_bus++;
        end
        @(posedge sysclk);
        wr_valid <= 1'b0;
    endtask

    task automatic read_and_check(input mcu_io_pkg::reg_addr_t addr);
        @(posedge sysclk);
        rd_addr <= addr;
        // rd_data is registered and valid after the next edge
        @(posedge sysclk);
        @(negedge sysclk);
        check_equal($sformatf("rd_data[%0d]", addr), 32'(rd_data), 32'(expected_read(addr)));
    endtask

    task automatic check_all();
        for (int i = 0; i < 16; i++) begin
            read_and_check(mcu_io_pkg::reg_addr_t'(i));
        end
    endtask

    task automatic wait_ready();
        @(negedge sysclk);
        while (!ready) begin
            @(negedge sysclk);
        end
    endtask

    // bus side compare against the expected command queue
    initial begin
        forever begin
            @(negedge sysclk);
            if (accepted) begin
                bus_writes++;
                check_equal("av_write", 32'(av_write), 32'd0);
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("bus write at %0t ns with no data register write pending", $time);
                end else begin
                    want_cmd = exp_q.pop_front();
                    check_equal("av_cmd.address", 32'(accepted_cmd.address),
                                32'(want_cmd.address));
                    check_equal("av_cmd.writedata", 32'(accepted_cmd.writedata),
                                32'(want_cmd.writedata));
                end
            end
        end
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge sysclk);
            cycles++;
        end
        $display("timeout after %0d cycles, the test sequence did not finish", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        for (int i = 0; i < 16; i++) begin
            ref_regs[i] = '0;
        end
        repeat (2) @(posedge sysclk);
        reset <= 1'b0;
        // ready held low one cycle and then up
        @(negedge sysclk);
        check_equal("ready", 32'(ready), 32'd0);
        check_equal("av_write", 32'(av_write), 32'd0);
        @(negedge sysclk);
        check_equal("ready", 32'(ready), 32'd1);
        check_all();

        // gp bank with a random neighbour read
        for (int i = 0; i < n_gp; i++) begin
            rnd = $random(seed);
            host_write({1'b0, rnd[18:16]}, rnd[15:0], took);
            read_and_check({1'b0, rnd[18:16]});
            read_and_check(rnd[23:20]);
        end
        check_all();

        // led byte
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            host_write(`MCU_IO_DR_LEDS, rnd[15:0], took);
            read_and_check(`MCU_IO_DR_LEDS);
            check_equal("leds", 32'(leds), 32'(ref_regs[`MCU_IO_DR_LEDS][7:0]));
        end
        // key and unmapped addresses take nothing
        for (int a = 11; a < 16; a++) begin
            rnd = $random(seed);
            host_write(mcu_io_pkg::reg_addr_t'(a), rnd[15:0], took);
        end
        check_all();
        check_equal("leds", 32'(leds), 32'(ref_regs[`MCU_IO_DR_LEDS][7:0]));

        // keys through the synchronizer, read exactly 3 cycles after the change
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            @(posedge sysclk);
            rd_addr <= `MCU_IO_SR_KEYS;
            keys    <= rnd[`MCU_IO_NUM_KEYS-1:0];
            ref_keys = rnd[`MCU_IO_NUM_KEYS-1:0];
            // two sync flops plus the read register
            repeat (3) @(posedge sysclk);
            @(negedge sysclk);
            check_equal("rd_data[11]", 32'(rd_data), 32'(expected_read(`MCU_IO_SR_KEYS)));
        end

        // bus writes under random waitrequest
        for (int i = 0; i < n_bus; i++) begin
            rnd = $random(seed);
            wait_ready();
            host_write(`MCU_IO_DR_AV_ADDRESS, rnd[31:16], took);
            host_write(`MCU_IO_DR_AV_WRITEDATA, rnd[15:0], took);
            check_equal("data write taken", 32'(took), 32'd1);
            read_and_check(`MCU_IO_DR_AV_ADDRESS);
            read_and_check(`MCU_IO_DR_AV_WRITEDATA);
        end

        // second data write lands while busy
        for (int i = 0; i < n_busy; i++) begin
            rnd = $random(seed);
            wait_ready();
            host_write(`MCU_IO_DR_AV_WRITEDATA, rnd[15:0], took);
            host_write(`MCU_IO_DR_AV_WRITEDATA, rnd[31:16], took);
            check_equal("busy data write taken", 32'(took), 32'd0);
            // gp side never blocked by the bus
            host_write({1'b0, rnd[18:16]}, ~rnd[15:0], took);
            read_and_check({1'b0, rnd[18:16]});
            read_and_check(`MCU_IO_DR_AV_WRITEDATA);
            wait_ready();
            read_and_check(`MCU_IO_DR_AV_WRITEDATA);
        end

        // drain the last transfer
        while (exp_q.size() != 0 || !ready) begin
            @(negedge sysclk);
        end
        repeat (2) @(negedge sysclk);
        check_equal("bus write count", 32'(bus_writes), 32'(want_bus));
        $display("errors %0d, checks %0d, bus writes %0d", errors, checks, bus_writes);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
